/* Bender.yml */
package:
  name: decode_stage

export_include_dirs:
  - include

sources:
  - design/drac_pkg.sv
  - design/fetch_rx.sv
  - design/immediate.sv
  - design/instr_decoder.sv
  - design/decode_tx.sv
  - design/decode_stage.sv
  - target: simulation
    files:
      - sim/tb_decode_stage.sv

/* decode_stage.f */
+incdir+include
design/drac_pkg.sv
design/fetch_rx.sv
design/immediate.sv
design/instr_decoder.sv
design/decode_tx.sv
design/decode_stage.sv
sim/tb_decode_stage.sv

/* design/decode_stage.sv */
// Decode stage top level for a small in-order RV64I core
// Both four-phase ports must share clk_i, there are no synchronizers
// Holds at most two instructions, one in fetch_rx and one in decode_tx
// Empty-stage latency is two edges from req sampled high to dec_req_o high
// Records leave in arrival order

`default_nettype none

module decode_stage
    import drac_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           fetch_req_i,
    input  fetch_item_t    fetch_item_i,
    output logic           fetch_ack_o,
    output logic           dec_req_o,
    input  logic           dec_ack_i,
    output decoded_instr_t dec_o
);

    fetch_item_t    buf_item;                         // Buffered fetch word and pc
    logic           buf_valid;
    logic           buf_ready;
    decoded_instr_t dec_comb;                         // Decoder output, combinational

    fetch_rx u_fetch_rx (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_item_i (fetch_item_i),
        .fetch_ack_o  (fetch_ack_o),
        .buf_item_o   (buf_item),
        .buf_valid_o  (buf_valid),
        .buf_ready_i  (buf_ready)
    );

    instr_decoder u_instr_decoder (
        .item_i (buf_item),
        .dec_o  (dec_comb)
    );

    decode_tx u_decode_tx (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .dec_i       (dec_comb),
        .buf_valid_i (buf_valid),
        .buf_ready_o (buf_ready),
        .dec_req_o   (dec_req_o),
        .dec_ack_i   (dec_ack_i),
        .dec_o       (dec_o)
    );

endmodule

`default_nettype wire

/* design/decode_tx.sv */
// Output side of the decode stage, one-entry buffer and four-phase sender
// dec_ack_i is sampled directly, so the consumer must be in the clk_i domain
// The buffer accepts a new record only after the full req/ack cycle ends,
// so at most one record is offered at a time

`default_nettype none

module decode_tx
    import drac_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  decoded_instr_t dec_i,
    input  logic           buf_valid_i,
    output logic           buf_ready_o,
    output logic           dec_req_o,
    input  logic           dec_ack_i,
    output decoded_instr_t dec_o
);

    typedef enum logic [1:0] {
        TX_IDLE,                                      // Buffer empty, ready high
        TX_REQ,                                       // Req high, waiting for ack
        TX_WAIT                                       // Req dropped, waiting for ack low
    } tx_state_e;

    tx_state_e      state_q;
    decoded_instr_t dec_q;                            // Payload, no reset
    logic           xfer;

    assign buf_ready_o = (state_q == TX_IDLE);
    assign xfer        = buf_valid_i && buf_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TX_IDLE;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (xfer) begin
                        state_q <= TX_REQ;            // Req rises after the transfer edge
                    end
                end
                TX_REQ: begin
                    if (dec_ack_i) begin
                        state_q <= TX_WAIT;           // Phase 3
                    end
                end
                TX_WAIT: begin
                    if (!dec_ack_i) begin
                        state_q <= TX_IDLE;           // Phase 4 done, buffer free
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer) begin
            dec_q <= dec_i;
        end
    end

    assign dec_req_o = (state_q == TX_REQ);
    assign dec_o     = dec_q;

    // Data must hold from req rise through the ack
    dec_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_req_o |=> $stable(dec_o));

endmodule

`default_nettype wire

/* design/drac_pkg.sv */
// Types for the RV64I decode stage
// Only the base integer opcodes are listed; anything else decodes as illegal
// instruction_t is the one word viewed in the standard R/I/S/B/U/J layouts
// The CSR func3 set holds only the immediate forms the generator needs

`default_nettype none

`include "drac_decode_macros.svh"

package drac_pkg;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_ALU_I   = 7'b0010011,
        OP_ALU_I_W = 7'b0011011,
        OP_ALU     = 7'b0110011,
        OP_ALU_W   = 7'b0111011,
        OP_SYSTEM  = 7'b1110011
    } opcode_e;

    // CSR forms with a 5-bit zero-extended immediate in the rs1 slot
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0]                  func7;
            logic [`DRAC_REG_ADDR_W-1:0] rs2;
            logic [`DRAC_REG_ADDR_W-1:0] rs1;
            logic [2:0]                  func3;
            logic [`DRAC_REG_ADDR_W-1:0] rd;
            opcode_e                     opcode;
        } common;                                     // R-type layout
        struct packed {
            logic [11:0]                 imm;         // imm[11:0]
            logic [`DRAC_REG_ADDR_W-1:0] rs1;
            logic [2:0]                  func3;
            logic [`DRAC_REG_ADDR_W-1:0] rd;
            opcode_e                     opcode;
        } itype;
        struct packed {
            logic [6:0]                  imm5;        // imm[11:5]
            logic [`DRAC_REG_ADDR_W-1:0] rs2;
            logic [`DRAC_REG_ADDR_W-1:0] rs1;
            logic [2:0]                  func3;
            logic [4:0]                  imm0;        // imm[4:0]
            opcode_e                     opcode;
        } stype;
        struct packed {
            logic                        imm12;       // imm[12], sign
            logic [5:0]                  imm5;        // imm[10:5]
            logic [`DRAC_REG_ADDR_W-1:0] rs2;
            logic [`DRAC_REG_ADDR_W-1:0] rs1;
            logic [2:0]                  func3;
            logic [3:0]                  imm1;        // imm[4:1]
            logic                        imm11;       // imm[11]
            opcode_e                     opcode;
        } btype;
        struct packed {
            logic [19:0]                 imm;         // imm[31:12]
            logic [`DRAC_REG_ADDR_W-1:0] rd;
            opcode_e                     opcode;
        } utype;
        struct packed {
            logic                        imm20;       // imm[20], sign
            logic [9:0]                  imm1;        // imm[10:1]
            logic                        imm11;       // imm[11]
            logic [7:0]                  imm12;       // imm[19:12]
            logic [`DRAC_REG_ADDR_W-1:0] rd;
            opcode_e                     opcode;
        } jtype;
    } instruction_t;

    typedef enum logic [3:0] {
        CLS_ALU, CLS_ALU_IMM, CLS_LOAD, CLS_STORE, CLS_BRANCH,
        CLS_JAL, CLS_JALR, CLS_LUI, CLS_AUIPC, CLS_CSR,
        CLS_CSR_IMM, CLS_SYSTEM, CLS_ILLEGAL
    } instr_class_e;

    typedef struct packed {
        logic [`DRAC_XLEN-1:0] pc;
        instruction_t          instr;
    } fetch_item_t;                                   // 96 bits

    typedef struct packed {
        logic [`DRAC_XLEN-1:0]       pc;
        instr_class_e                cls;
        logic [`DRAC_REG_ADDR_W-1:0] rd;
        logic [`DRAC_REG_ADDR_W-1:0] rs1;
        logic [`DRAC_REG_ADDR_W-1:0] rs2;
        logic [2:0]                  func3;
        logic [`DRAC_XLEN-1:0]       imm;
    } decoded_instr_t;                                // 150 bits

endpackage

`default_nettype wire

/* design/fetch_rx.sv */
// Input side of the decode stage, four-phase receiver with a one-entry buffer
// fetch_req_i is sampled directly, so the producer must be in the clk_i domain
// While the buffer is full the ack is held off, which stalls the producer
// Internal side is a plain valid/ready, transfer on an edge with both high

`default_nettype none

module fetch_rx
    import drac_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_req_i,
    input  fetch_item_t fetch_item_i,
    output logic        fetch_ack_o,
    output fetch_item_t buf_item_o,
    output logic        buf_valid_o,
    input  logic        buf_ready_i
);

    typedef enum logic {
        RX_IDLE,                                      // Ack low, waiting for req
        RX_ACK                                        // Ack high until req drops
    } rx_state_e;

    rx_state_e   state_q;
    fetch_item_t item_q;                              // Payload, no reset
    logic        valid_q;
    logic        capture;
    logic        xfer;

    assign capture = (state_q == RX_IDLE) && fetch_req_i && !valid_q; // Only when empty
    assign xfer    = valid_q && buf_ready_i;          // Handoff to decode_tx

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            valid_q <= 1'b0;
        end else begin
            if (capture) begin
                state_q <= RX_ACK;                    // Ack goes out after capture
            end else if ((state_q == RX_ACK) && !fetch_req_i) begin
                state_q <= RX_IDLE;                   // Phase 4, release ack
            end
            if (capture) begin
                valid_q <= 1'b1;
            end else if (xfer) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            item_q <= fetch_item_i;
        end
    end

    assign fetch_ack_o = (state_q == RX_ACK);
    assign buf_item_o  = item_q;
    assign buf_valid_o = valid_q;

    // A new ack needs a request, so ack never rises against a low req
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !fetch_ack_o && !fetch_req_i |=> !fetch_ack_o);

endmodule

`default_nettype wire

/* design/immediate.sv */
// Immediate generator for RV64I, purely combinational
// I, S, B, U and J immediates are sign-extended from instruction bit 31 to XLEN
// CSRRWI, CSRRSI and CSRRCI return rs1 zero-extended as the CSR immediate
// Register-register, unknown opcodes and other SYSTEM func3 values give zero

`default_nettype none

`include "drac_decode_macros.svh"

module immediate
    import drac_pkg::*;
(
    input  instruction_t          instr_i,
    output logic [`DRAC_XLEN-1:0] imm_o
);

    logic                  sign;
    logic [`DRAC_XLEN-1:0] imm_itype;
    logic [`DRAC_XLEN-1:0] imm_stype;
    logic [`DRAC_XLEN-1:0] imm_btype;
    logic [`DRAC_XLEN-1:0] imm_utype;
    logic [`DRAC_XLEN-1:0] imm_jtype;
    logic [`DRAC_XLEN-1:0] imm_csr;

    assign sign = instr_i[`DRAC_ILEN-1];              // Bit 31 in every signed form

    assign imm_itype = {{(`DRAC_XLEN-12){sign}}, instr_i.itype.imm};
    assign imm_stype = {{(`DRAC_XLEN-12){sign}}, instr_i.stype.imm5, instr_i.stype.imm0};

    // 13-bit offset, so 51 copies of the sign on a 64-bit core
    assign imm_btype = {{(`DRAC_XLEN-13){sign}},
                        instr_i.btype.imm12,
                        instr_i.btype.imm11,
                        instr_i.btype.imm5,
                        instr_i.btype.imm1,
                        1'b0};

    assign imm_utype = {{(`DRAC_XLEN-32){sign}}, instr_i.utype.imm, 12'b0};

    // 21-bit offset, 43 sign copies
    assign imm_jtype = {{(`DRAC_XLEN-21){sign}},
                        instr_i.jtype.imm20,
                        instr_i.jtype.imm12,
                        instr_i.jtype.imm11,
                        instr_i.jtype.imm1,
                        1'b0};

    // uimm in the rs1 slot, never sign-extended
    assign imm_csr = {{(`DRAC_XLEN-`DRAC_REG_ADDR_W){1'b0}}, instr_i.common.rs1};

    always_comb begin
        case (instr_i.common.opcode)
            OP_LUI,
            OP_AUIPC: begin
                imm_o = imm_utype;
            end
            OP_JAL: begin
                imm_o = imm_jtype;
            end
            OP_JALR,
            OP_LOAD,
            OP_ALU_I,
            OP_ALU_I_W: begin
                imm_o = imm_itype;
            end
            OP_BRANCH:  imm_o = imm_btype;
            OP_STORE:   imm_o = imm_stype;
            OP_SYSTEM: begin
                case (instr_i.itype.func3)
                    F3_CSRRWI,
                    F3_CSRRSI,
                    F3_CSRRCI: imm_o = imm_csr;
                    default:   imm_o = '0;            // CSR reg forms, func3 0 and 4
                endcase
            end
            default: imm_o = '0;                      // R-type and unknown opcodes
        endcase
    end

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
// Field split and class decode for one fetched instruction, zero latency
// Only RV64I base opcodes are recognised, all others are CLS_ILLEGAL
// SYSTEM func3 0 is treated as illegal, func3 4 maps to CLS_SYSTEM
// rd, rs1, rs2 and func3 are copied from their fixed positions for every class,
// so consumers must ignore the fields a class does not use

`default_nettype none

`include "drac_decode_macros.svh"

module instr_decoder
    import drac_pkg::*;
(
    input  fetch_item_t    item_i,
    output decoded_instr_t dec_o
);

    instruction_t          instr;
    logic [2:0]            func3;
    instr_class_e          cls;
    logic [`DRAC_XLEN-1:0] imm;

    assign instr = item_i.instr;
    assign func3 = instr.common.func3;

    immediate u_immediate (
        .instr_i (instr),
        .imm_o   (imm)
    );

    // Opcode to class, SYSTEM split further on func3
    always_comb begin
        case (instr.common.opcode)
            OP_LUI:     cls = CLS_LUI;
            OP_AUIPC:   cls = CLS_AUIPC;
            OP_JAL:     cls = CLS_JAL;
            OP_JALR:    cls = CLS_JALR;
            OP_BRANCH:  cls = CLS_BRANCH;
            OP_LOAD:    cls = CLS_LOAD;
            OP_STORE:   cls = CLS_STORE;
            OP_ALU_I,
            OP_ALU_I_W: cls = CLS_ALU_IMM;
            OP_ALU,
            OP_ALU_W:   cls = CLS_ALU;                // Word ops share the ALU class
            OP_SYSTEM: begin
                case (func3)
                    3'b000:    cls = CLS_ILLEGAL;     // No ECALL/EBREAK support here
                    3'b100:    cls = CLS_SYSTEM;
                    F3_CSRRWI,
                    F3_CSRRSI,
                    F3_CSRRCI: cls = CLS_CSR_IMM;
                    default:   cls = CLS_CSR;         // CSRRW, CSRRS, CSRRC
                endcase
            end
            default:    cls = CLS_ILLEGAL;
        endcase
    end

    always_comb begin
        dec_o       = '0;
        dec_o.pc    = item_i.pc;
        dec_o.cls   = cls;
        dec_o.rd    = instr.common.rd;
        dec_o.rs1   = instr.common.rs1;
        dec_o.rs2   = instr.common.rs2;
        dec_o.func3 = func3;
        dec_o.imm   = imm;                            // Generator already zeroes illegal words
    end

    // Class decode and immediate select must agree on what is illegal
    always_comb begin
        ill_imm_zero: assert #0 (cls != CLS_ILLEGAL || imm == '0)
            else $error("illegal instruction with nonzero immediate");
    end

    // Register-register forms never carry an immediate
    always_comb begin
        alu_imm_zero: assert #0 (cls != CLS_ALU || imm == '0)
            else $error("register-register instruction with nonzero immediate");
    end

endmodule

`default_nettype wire

/* include/drac_decode_macros.svh */
// Width macros shared by the decode stage package and RTL
// RV64I only, so XLEN is fixed at 64 and compressed forms are not supported
// Instruction length is the uncompressed 32-bit encoding
// Register addresses cover the 32 integer registers, no FP file

`ifndef DRAC_DECODE_MACROS_SVH
`define DRAC_DECODE_MACROS_SVH

// Data path width, also the width of pc and of the sign-extended immediate
`define DRAC_XLEN 64

// Fetched instruction word width
`define DRAC_ILEN 32

// Integer register index width (x0..x31)
`define DRAC_REG_ADDR_W 5

// The instruction_t union and the decoded record in drac_pkg are sized from
// these three values. Changing ILEN alone breaks the union views, which are
// laid out for the 32-bit base encoding.
// XLEN below 32 is not meaningful for the immediate generator, since the U
// immediate already occupies bits 31:12.
// REG_ADDR_W must stay 5 while the union views place rs1, rs2 and rd at
// their base ISA bit positions.

`endif

/* sim/tb_decode_stage.sv */
// Testbench for the RV64I decode stage
// Words come from a 32-bit Fibonacci LFSR, the opcode is forced afterwards
// Concurrent assertions compare each offered record with a queue of expected
// records, so records must leave in the order they were sent
// Every wait is bounded by timeout_cycles and a timeout counts as an error

`default_nettype none

`include "drac_decode_macros.svh"

module tb_decode_stage
    import drac_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 100;              // Longest stall is the 30-cycle hold
    localparam opcode_e legal_ops [11] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
        OP_LOAD, OP_STORE, OP_ALU_I, OP_ALU_I_W, OP_ALU, OP_ALU_W};

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  fetch_req_i;
    fetch_item_t           fetch_item_i;
    logic                  fetch_ack_o;
    logic                  dec_req_o;
    logic                  dec_ack_i;
    decoded_instr_t        dec_o;

    logic [31:0]           lfsr_q;
    logic [31:0]           word;
    logic [`DRAC_XLEN-1:0] pc_next;
    logic [31:0]           word_q [$];                // Words of the current stream
    decoded_instr_t        exp_q [$];                 // Expected records, oldest first
    decoded_instr_t        exp_head;
    int                    exp_count;
    int                    in_stage;                  // Acked by the DUT, not yet taken
    bit                    seen_req;
    string                 test_name;
    int                    errors;
    int                    test_errors;
    int                    tests_run;
    int                    tests_failed;

    decode_stage u_dut (.*);

    always #2 clk_i = ~clk_i;                         // 4 ns period

    // Quiet outputs through reset and until the first request
    reset_quiet: assert property (@(posedge clk_i) !seen_req |-> !fetch_ack_o && !dec_req_o)
        else report_fail("fetch_ack_o or dec_req_o high before any request");
    rec_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_req_o |-> exp_count > 0)
        else report_fail("dec_req_o raised with no record outstanding");
    pc_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_req_o |-> dec_o.pc == exp_head.pc)
        else report_value("pc", exp_head.pc, dec_o.pc);
    cls_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_req_o |-> dec_o.cls == exp_head.cls)
        else report_value("cls", 64'(exp_head.cls), 64'(dec_o.cls));
    imm_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_req_o |-> dec_o.imm == exp_head.imm)
        else report_value("imm", exp_head.imm, dec_o.imm);
    field_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)   // rd rs1 rs2 func3
        dec_req_o |-> {dec_o.rd, dec_o.rs1, dec_o.rs2, dec_o.func3} ==
                      {exp_head.rd, exp_head.rs1, exp_head.rs2, exp_head.func3})
        else report_value("fields", 64'({exp_head.rd, exp_head.rs1, exp_head.rs2,
            exp_head.func3}), 64'({dec_o.rd, dec_o.rs1, dec_o.rs2, dec_o.func3}));
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_req_o && !dec_ack_i |=> dec_req_o && $stable(dec_o))
        else report_fail("dec_req_o dropped or dec_o changed before dec_ack_i");
    ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_ack_o && fetch_req_i |=> fetch_ack_o)
        else report_fail("fetch_ack_o fell while fetch_req_i was still high");
    no_third_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(fetch_ack_o) |-> in_stage <= 2)   // Count already includes the new item
        else report_fail("a third input was acknowledged while two were held");

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);               // One step per bit
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic bit is_known(input logic [6:0] op);
        bit hit;
        hit = (op == OP_SYSTEM);
        foreach (legal_ops[i]) begin
            hit = hit || (op == legal_ops[i]);
        end
        return hit;
    endfunction

    // Expected record, class first, then the immediate form that class uses
    function automatic decoded_instr_t ref_decode(input logic [63:0] pc, input logic [31:0] w);
        decoded_instr_t r;
        logic [63:0]    imm_i;
        logic [63:0]    imm_s;
        logic [63:0]    imm_b;
        logic [63:0]    imm_u;
        logic [63:0]    imm_j;
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};      // imm[12] is the sign
        imm_u = {{32{w[31]}}, w[31:12], 12'h000};
        imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};    // imm[20] is the sign
        r       = '0;
        r.pc    = pc;
        r.rd    = w[11:7];
        r.rs1   = w[19:15];
        r.rs2   = w[24:20];
        r.func3 = w[14:12];
        r.cls   = CLS_ILLEGAL;                        // Unknown opcodes stay illegal
        case (w[6:0])
            OP_LUI:             r.cls = CLS_LUI;
            OP_AUIPC:           r.cls = CLS_AUIPC;
            OP_JAL:             r.cls = CLS_JAL;
            OP_JALR:            r.cls = CLS_JALR;
            OP_BRANCH:          r.cls = CLS_BRANCH;
            OP_LOAD:            r.cls = CLS_LOAD;
            OP_STORE:           r.cls = CLS_STORE;
            OP_ALU_I, OP_ALU_I_W: r.cls = CLS_ALU_IMM;
            OP_ALU, OP_ALU_W:   r.cls = CLS_ALU;
            OP_SYSTEM: begin
                case (w[14:12])
                    3'd0:    r.cls = CLS_ILLEGAL;
                    3'd4:    r.cls = CLS_SYSTEM;
                    F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: r.cls = CLS_CSR_IMM;
                    default: r.cls = CLS_CSR;
                endcase
            end
            default: ;
        endcase
        case (r.cls)
            CLS_LUI, CLS_AUIPC:              r.imm = imm_u;
            CLS_JAL:                         r.imm = imm_j;
            CLS_JALR, CLS_LOAD, CLS_ALU_IMM: r.imm = imm_i;
            CLS_BRANCH:                      r.imm = imm_b;
            CLS_STORE:                       r.imm = imm_s;
            CLS_CSR_IMM:                     r.imm = {59'd0, w[19:15]};   // uimm, zero-extended
            default:                         r.imm = '0;
        endcase
        return r;
    endfunction

    task automatic report_value(input string what, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        errors++;
        $display("** Error %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("Error in test %s: %s", test_name, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #0.5;                                         // Drive point after the edge
    endtask

    task automatic sync_head();
        exp_count = exp_q.size();
        if (exp_count > 0) begin
            exp_head = exp_q[0];
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        int n;
        n = errors - test_errors;
        tests_run++;
        if (n > 0) begin
            tests_failed++;
        end
        $display("test %-16s %s, %0d errors", test_name, (n > 0) ? "failed" : "ok", n);
    endtask

    // Producer, one full four-phase cycle per word
    task automatic send_item(input logic [31:0] w);
        int t;
        exp_q.push_back(ref_decode(pc_next, w));
        sync_head();
        fetch_item_i.pc    = pc_next;
        fetch_item_i.instr = w;
        fetch_req_i        = 1'b1;
        seen_req           = 1'b1;
        pc_next            = pc_next + 64'd4;
        t = 0;
        while (!fetch_ack_o && t < timeout_cycles) begin
            next_cycle();
            t++;
        end
        if (!fetch_ack_o) begin
            report_fail("producer saw no fetch_ack_o before the timeout");
        end else begin
            in_stage++;
        end
        repeat (int'(rand_bits(1))) next_cycle();     // Sometimes keep req high a while
        fetch_req_i = 1'b0;
        t = 0;
        while (fetch_ack_o && t < timeout_cycles) begin
            next_cycle();
            t++;
        end
        if (fetch_ack_o) begin
            report_fail("fetch_ack_o stayed high after fetch_req_i fell");
        end
    endtask

    // Consumer, hold is the delay from seeing req to raising ack
    task automatic take_item(input int hold, input bit check_full);
        int t;
        t = 0;
        while (!dec_req_o && t < timeout_cycles) begin
            next_cycle();
            t++;
        end
        if (!dec_req_o) begin
            report_fail("consumer saw no dec_req_o before the timeout");
            return;
        end
        repeat (hold) next_cycle();
        if (check_full) begin
            full_stall: assert (in_stage == 2 && fetch_req_i && !fetch_ack_o)
                else report_fail("stage did not hold two items with a third one waiting");
        end
        dec_ack_i = 1'b1;
        t = 0;
        while (dec_req_o && t < timeout_cycles) begin
            next_cycle();
            t++;
        end
        if (dec_req_o) begin
            report_fail("dec_req_o stayed high after dec_ack_i rose");
        end
        if (exp_q.size() > 0) begin
            exp_q.delete(0);                          // Pop only once req is low
        end
        in_stage--;
        sync_head();
        dec_ack_i = 1'b0;
    endtask

    task automatic run_stream(input int first_hold, input bit rand_hold);
        int n;
        n = word_q.size();
        fork
            begin
                foreach (word_q[i]) begin
                    send_item(word_q[i]);
                end
            end
            begin
                for (int i = 0; i < n; i++) begin
                    if (i == 0 && first_hold > 0) begin
                        take_item(first_hold, 1'b1);
                    end else begin
                        take_item(rand_hold ? int'(rand_bits(2)) : 0, 1'b0);
                    end
                end
            end
        join
        word_q.delete();
        none_lost: assert (exp_q.size() == 0)
            else report_fail("records were lost or never offered");
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_item_i = '0;
        dec_ack_i    = 1'b0;
        lfsr_q       = 32'h3056_8f29;
        word         = '0;
        pc_next      = 64'hffff_fff0_8000_0000;       // High bit set, catches pc truncation
        exp_head     = '0;
        exp_count    = 0;
        in_stage     = 0;
        seen_req     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        start_test("reset");
        repeat (4) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;
        repeat (3) next_cycle();                      // Still no request
        end_test();

        start_test("legal_opcodes");
        foreach (legal_ops[i]) begin
            for (int k = 0; k < 6; k++) begin
                word      = rand_bits(32);
                word[6:0] = legal_ops[i];
                word[31]  = word[31] | k[0];          // Odd k forces the sign bit
                word_q.push_back(word);
            end
        end
        run_stream(0, 1'b1);
        end_test();

        start_test("system");
        for (int f = 0; f < 16; f++) begin
            word        = rand_bits(32);
            word[6:0]   = OP_SYSTEM;
            word[14:12] = 3'(f);
            word[31]    = f[3];
            word_q.push_back(word);
        end
        run_stream(0, 1'b1);
        end_test();

        start_test("unknown_opcodes");
        for (int op = 0; op < 128; op++) begin
            if (!is_known(7'(op))) begin
                word      = rand_bits(32);
                word[6:0] = 7'(op);
                word_q.push_back(word);
            end
        end
        run_stream(0, 1'b1);
        end_test();

        start_test("back_pressure");
        for (int k = 0; k < 3; k++) begin
            word      = rand_bits(32);
            word[6:0] = legal_ops[k];
            word_q.push_back(word);
        end
        run_stream(30, 1'b0);                         // Third request waits out the hold
        end_test();

        start_test("protocol");
        for (int k = 0; k < 24; k++) begin
            word      = rand_bits(32);
            word[6:0] = legal_ops[rand_bits(4) % 11];
            word_q.push_back(word);
        end
        run_stream(0, 1'b1);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
